//--- files.f
+incdir+include
source/hwloop_pkg.sv
source/hwloop_wb_regs.sv
source/hwloop_controller.sv
source/fetch_pc_gen.sv
source/fetch_fifo.sv
source/hwloop_fetch_top.sv
test/tb_hwloop_fetch.sv

//--- include/hwloop_macros.svh
`ifndef HWLOOP_MACROS_SVH
`define HWLOOP_MACROS_SVH

`define HWLOOP_NUM  4       // loop 0 is the innermost
`define PC_AWID     15      // fetch address bits
`define FIFO_DEPTH  4

// word offsets inside one loop block, loop k starts at word 4k
`define REG_START   2'd0
`define REG_END     2'd1
`define REG_COUNT   2'd2

`define REG_CTRL    5'd16   // bit 0 is run
`define REG_HALT    5'd17

`endif

//--- run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
( verilator --binary --timing --assert -Wno-fatal --top-module tb_hwloop_fetch \
    -f files.f -o sim_hwloop_fetch && ./obj_dir/sim_hwloop_fetch ) > sim.log 2>&1
grep -q "^=== PASS ===$" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }

//--- source/fetch_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "hwloop_macros.svh"

module fetch_fifo
    import hwloop_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic push_i,
    input  wire pc_t  push_pc_i,
    input  wire logic issue_ready_i,   // decode stage takes a word

    output logic      full_o,
    output logic      issue_valid_o,
    output pc_t       issue_pc_o
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam logic [PTR_W:0] DEPTH_CNT = `FIFO_DEPTH;

    pc_t              mem_q [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(`FIFO_DEPTH-1))
            return '0;
        return p + 1'b1;
    endfunction

    assign pop = issue_valid_o & issue_ready_i;

    always_ff @(posedge clk_i) begin
        if (push_i)
            mem_q[wr_ptr_q] <= push_pc_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i)
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop)
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            if (push_i && !pop)
                count_q <= count_q + 1'b1;
            else if (pop && !push_i)
                count_q <= count_q - 1'b1;
        end
    end

    assign full_o        = (count_q == DEPTH_CNT);
    assign issue_valid_o = (count_q != '0);
    assign issue_pc_o    = mem_q[rd_ptr_q];     // head of queue

    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
        push_i |-> !full_o);

    // held word must not move until the decode stage takes it
    a_issue_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        issue_valid_o && !issue_ready_i |=> issue_valid_o && $stable(issue_pc_o));

endmodule

`default_nettype wire

//--- source/fetch_pc_gen.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_pc_gen
    import hwloop_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic run_i,
    input  wire logic fifo_full_i,
    input  wire pc_t  halt_pc_i,
    input  wire logic loop_jump_i,     // redirect from loop controller
    input  wire pc_t  loop_target_i,

    output pc_t       fetch_pc_o,
    output logic      fetch_fire_o,
    output logic      halt_hit_o       // last fetch, run clears
);

    pc_t  pc_q;
    pc_t  pc_next;
    logic fire;

    assign fire    = run_i & ~fifo_full_i;  // stall while fifo full
    assign pc_next = loop_jump_i ? loop_target_i : pc_q + 1'b1;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= '0;
        end else if (!run_i) begin
            pc_q <= '0;         // idle, next run starts at 0
        end else if (fire) begin
            pc_q <= pc_next;
        end
    end

    assign fetch_pc_o   = pc_q;
    assign fetch_fire_o = fire;
    assign halt_hit_o   = fire & (pc_q == halt_pc_i);

    // register file must drop run right after the halt fetch
    a_halt_stops: assert property (@(posedge clk_i) disable iff (rst_i)
        halt_hit_o |=> !fetch_fire_o);

endmodule

`default_nettype wire

//--- source/hwloop_controller.sv
`timescale 1ns/1ns
`default_nettype none

`include "hwloop_macros.svh"

module hwloop_controller
    import hwloop_pkg::*;
(
    input  wire pc_t        current_pc_i,            // fetch address this cycle
    input  wire logic       fetch_fire_i,

    // from loop register file
    input  wire loop_addr_t loop_start_addr_i,
    input  wire loop_addr_t loop_end_addr_i,
    input  wire loop_cnt_t  loop_counter_i,
    input  wire loop_mask_t loop_cnt_dec_pending_i,  // decrements not yet applied

    // to pc generator
    output logic            loop_jump_o,
    output pc_t             loop_target_addr_o,

    output loop_mask_t      loop_cnt_dec_o           // to loop register file
);

    loop_mask_t end_hit;

    // end address match, counter must allow one more pass
    always_comb begin
        for (int k = 0; k < `HWLOOP_NUM; k++) begin
            end_hit[k] = fetch_fire_i
                && (current_pc_i == loop_end_addr_i[k][`PC_AWID-1:0])
                && (loop_cnt_dec_pending_i[k] ? (loop_counter_i[k] >= 32'd3)
                                              : (loop_counter_i[k] >= 32'd2));
        end
    end

    // inner loop wins, so walk from the outermost down
    always_comb begin
        loop_target_addr_o = '0;
        loop_cnt_dec_o     = '0;
        for (int k = `HWLOOP_NUM-1; k >= 0; k--) begin
            if (end_hit[k]) begin
                loop_target_addr_o = loop_start_addr_i[k][`PC_AWID-1:0];
                loop_cnt_dec_o     = loop_mask_t'(1) << k;
            end
        end
    end

    assign loop_jump_o = |end_hit;

    always_comb begin
        a_dec_onehot: assert final ($onehot0(loop_cnt_dec_o))
            else $error("more than one loop decremented");
        a_jump_dec: assert final (loop_jump_o == (|loop_cnt_dec_o))
            else $error("jump without matching decrement");
    end

endmodule

`default_nettype wire

//--- source/hwloop_fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module hwloop_fetch_top
    import hwloop_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_i,

    // host port
    input  wire logic        wb_cyc_i,
    input  wire logic        wb_stb_i,
    input  wire logic        wb_we_i,
    input  wire reg_idx_t    wb_adr_i,
    input  wire logic [31:0] wb_dat_i,
    output logic [31:0]      wb_dat_o,
    output logic             wb_ack_o,

    // issue port to decode
    output logic             issue_valid_o,
    output pc_t              issue_pc_o,
    input  wire logic        issue_ready_i
);

    loop_addr_t loop_start;
    loop_addr_t loop_end;
    loop_cnt_t  loop_counter;
    loop_mask_t dec_pending;
    loop_mask_t loop_cnt_dec;
    logic       run;
    pc_t        halt_pc;
    logic       halt_hit;

    pc_t        fetch_pc;
    logic       fetch_fire;
    logic       loop_jump;
    pc_t        loop_target;
    logic       fifo_full;

    hwloop_wb_regs u_regs (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .loop_cnt_dec_i (loop_cnt_dec),
        .halt_hit_i     (halt_hit),
        .loop_start_o   (loop_start),
        .loop_end_o     (loop_end),
        .loop_counter_o (loop_counter),
        .dec_pending_o  (dec_pending),
        .run_o          (run),
        .halt_pc_o      (halt_pc)
    );

    hwloop_controller u_ctrl (
        .current_pc_i           (fetch_pc),
        .fetch_fire_i           (fetch_fire),
        .loop_start_addr_i      (loop_start),
        .loop_end_addr_i        (loop_end),
        .loop_counter_i         (loop_counter),
        .loop_cnt_dec_pending_i (dec_pending),
        .loop_jump_o            (loop_jump),
        .loop_target_addr_o     (loop_target),
        .loop_cnt_dec_o         (loop_cnt_dec)
    );

    fetch_pc_gen u_pc (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .run_i         (run),
        .fifo_full_i   (fifo_full),
        .halt_pc_i     (halt_pc),
        .loop_jump_i   (loop_jump),
        .loop_target_i (loop_target),
        .fetch_pc_o    (fetch_pc),
        .fetch_fire_o  (fetch_fire),
        .halt_hit_o    (halt_hit)
    );

    fetch_fifo u_fifo (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .push_i        (fetch_fire),     // every fetched pc is queued
        .push_pc_i     (fetch_pc),
        .issue_ready_i (issue_ready_i),
        .full_o        (fifo_full),
        .issue_valid_o (issue_valid_o),
        .issue_pc_o    (issue_pc_o)
    );

endmodule

`default_nettype wire

//--- source/hwloop_pkg.sv
`default_nettype none

`include "hwloop_macros.svh"

package hwloop_pkg;

    // start or end address, one word per loop
    typedef logic [`HWLOOP_NUM-1:0][31:0] loop_addr_t;

    // iteration counters
    typedef logic [`HWLOOP_NUM-1:0][31:0] loop_cnt_t;

    typedef logic [`HWLOOP_NUM-1:0]       loop_mask_t;  // bit k is loop k

    typedef logic [`PC_AWID-1:0]          pc_t;

    // wishbone word index into the register map
    typedef logic [4:0]                   reg_idx_t;

endpackage

`default_nettype wire

//--- source/hwloop_wb_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "hwloop_macros.svh"

module hwloop_wb_regs
    import hwloop_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_i,

    // wishbone classic slave
    input  wire logic        wb_cyc_i,
    input  wire logic        wb_stb_i,
    input  wire logic        wb_we_i,
    input  wire reg_idx_t    wb_adr_i,
    input  wire logic [31:0] wb_dat_i,
    output logic [31:0]      wb_dat_o,
    output logic             wb_ack_o,

    input  wire loop_mask_t  loop_cnt_dec_i,   // from controller
    input  wire logic        halt_hit_i,       // from pc generator

    output loop_addr_t       loop_start_o,
    output loop_addr_t       loop_end_o,
    output loop_cnt_t        loop_counter_o,
    output loop_mask_t       dec_pending_o,
    output logic             run_o,
    output pc_t              halt_pc_o
);

    loop_addr_t  loop_start_q;
    loop_addr_t  loop_end_q;
    loop_cnt_t   loop_counter_q;
    loop_mask_t  dec_pending_q;     // decrement requested last cycle
    logic        run_q;
    pc_t         halt_pc_q;
    logic        ack_q;
    logic [31:0] dat_q;

    logic        wb_req;
    logic        wr_en;
    logic        in_loop_blk;
    logic [1:0]  loop_sel;
    logic [1:0]  reg_sel;
    logic [31:0] rd_data;

    assign wb_req      = wb_cyc_i & wb_stb_i & ~ack_q;  // new access, ack not yet given
    assign wr_en       = wb_req & wb_we_i;
    assign in_loop_blk = ~wb_adr_i[4];
    assign loop_sel    = wb_adr_i[3:2];
    assign reg_sel     = wb_adr_i[1:0];

    // read mux
    always_comb begin
        rd_data = '0;
        if (in_loop_blk) begin
            if (reg_sel == `REG_START)
                rd_data = loop_start_q[loop_sel];
            else if (reg_sel == `REG_END)
                rd_data = loop_end_q[loop_sel];
            else if (reg_sel == `REG_COUNT)
                rd_data = loop_counter_q[loop_sel];  // live value
        end else if (wb_adr_i == `REG_CTRL) begin
            rd_data = {31'b0, run_q};
        end else if (wb_adr_i == `REG_HALT) begin
            rd_data = 32'(halt_pc_q);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q          <= 1'b0;
            dat_q          <= '0;
            loop_start_q   <= '0;
            loop_end_q     <= '0;
            loop_counter_q <= '0;
            dec_pending_q  <= '0;
            run_q          <= 1'b0;
            halt_pc_q      <= '0;
        end else begin
            ack_q         <= wb_req;
            dec_pending_q <= loop_cnt_dec_i;
            if (wb_req)
                dat_q <= rd_data;

            // decrement lands one cycle after the request
            for (int k = 0; k < `HWLOOP_NUM; k++) begin
                if (dec_pending_q[k])
                    loop_counter_q[k] <= loop_counter_q[k] - 32'd1;
            end

            if (halt_hit_i)
                run_q <= 1'b0;

            if (wr_en && in_loop_blk) begin
                if (reg_sel == `REG_START)
                    loop_start_q[loop_sel] <= wb_dat_i;
                if (reg_sel == `REG_END)
                    loop_end_q[loop_sel] <= wb_dat_i;
                if (reg_sel == `REG_COUNT)
                    loop_counter_q[loop_sel] <= wb_dat_i;
            end
            if (wr_en && wb_adr_i == `REG_CTRL)
                run_q <= wb_dat_i[0];
            if (wr_en && wb_adr_i == `REG_HALT)
                halt_pc_q <= wb_dat_i[`PC_AWID-1:0];
        end
    end

    assign wb_ack_o       = ack_q;
    assign wb_dat_o       = dat_q;
    assign loop_start_o   = loop_start_q;
    assign loop_end_o     = loop_end_q;
    assign loop_counter_o = loop_counter_q;
    assign dec_pending_o  = dec_pending_q;
    assign run_o          = run_q;
    assign halt_pc_o      = halt_pc_q;

    // single cycle ack even when the master holds stb
    a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_ack_o |=> !wb_ack_o);

endmodule

`default_nettype wire

//--- test/tb_hwloop_fetch.sv
`timescale 1ns/1ns
`default_nettype none

`include "hwloop_macros.svh"

module tb_hwloop_fetch
    import hwloop_pkg::*;
();

    localparam int WB_LIMIT   = 20;     // cycles to wait for an ack
    localparam int WAIT_LIMIT = 2000;   // cycles to wait for a whole stream

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    reg_idx_t    wb_adr;
    logic [31:0] wb_wdat;
    logic [31:0] wb_rdat;
    logic        wb_ack;
    logic        issue_valid;
    pc_t         issue_pc;
    logic        issue_ready;

    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errs_at_start = 0;
    bit          timeout_hit = 0;
    bit          bp_mode = 0;       // random issue_ready when set
    string       cur_test = "none";
    pc_t         exp_q [$];         // expected issue stream
    logic [31:0] cfg_start [`HWLOOP_NUM];
    logic [31:0] cfg_end   [`HWLOOP_NUM];
    logic [31:0] cfg_count [`HWLOOP_NUM];

    hwloop_fetch_top uut (
        .clk_i         (clk),
        .rst_i         (rst),
        .wb_cyc_i      (wb_cyc),
        .wb_stb_i      (wb_stb),
        .wb_we_i       (wb_we),
        .wb_adr_i      (wb_adr),
        .wb_dat_i      (wb_wdat),
        .wb_dat_o      (wb_rdat),
        .wb_ack_o      (wb_ack),
        .issue_valid_o (issue_valid),
        .issue_pc_o    (issue_pc),
        .issue_ready_i (issue_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // decode stage takes one lfsr step per ready bit
    initial begin
        logic [31:0] lfsr;
        lfsr = 32'h5df6;
        issue_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (bp_mode) begin
                lfsr = lfsr_next(lfsr);
                issue_ready = lfsr[0];
            end else begin
                issue_ready = 1'b1;
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("Fail %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // issue monitor against the model queue
    always @(posedge clk) begin
        if (!rst && issue_valid && issue_ready) begin
            assert (exp_q.size() > 0) else begin
                $display("test %s: extra transfer of pc %0h after the stream ended",
                         cur_test, issue_pc);
                errors++;
            end
            if (exp_q.size() > 0) begin
                check_value("issue pc", 32'(exp_q[0]), 32'(issue_pc));
                void'(exp_q.pop_front());
            end
        end
    end

    task automatic wb_access(input bit we, input reg_idx_t adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int n;
        n = 0;
        @(negedge clk);
        wb_cyc  = 1'b1;
        wb_stb  = 1'b1;
        wb_we   = we;
        wb_adr  = adr;
        wb_wdat = wdat;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack && n < WB_LIMIT);
        if (!wb_ack) begin
            $display("test %s: no Wishbone ack at word %0d within %0d cycles",
                     cur_test, adr, WB_LIMIT);
            timeout_hit = 1'b1;
        end
        rdat = wb_rdat;     // valid with ack
        @(negedge clk);     // stb still held over the edge after ack
        assert (timeout_hit || !wb_ack) else begin
            $display("test %s: Wishbone ack stayed high for a second cycle", cur_test);
            errors++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input reg_idx_t adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input reg_idx_t adr, output logic [31:0] dat);
        wb_access(1'b0, adr, 32'h0, dat);
    endtask

    function automatic reg_idx_t loop_adr(input int k, input logic [1:0] r);
        return reg_idx_t'(4 * k + int'(r));
    endfunction

    // distinct word for every loop register
    function automatic logic [31:0] reg_pattern(input int k, input int r);
        return 32'hA5C3_0000 ^ (k << 12) ^ (r << 4) ^ 32'h0000_0F0F;
    endfunction

    task automatic set_loop(input int k, input logic [31:0] s, input logic [31:0] e,
                            input logic [31:0] c);
        cfg_start[k] = s;
        cfg_end[k]   = e;
        cfg_count[k] = c;
        wb_write(loop_adr(k, `REG_START), s);
        wb_write(loop_adr(k, `REG_END), e);
        wb_write(loop_adr(k, `REG_COUNT), c);
    endtask

    // expected stream where a taken loop jumps back while its count is 2 or more
    task automatic build_expected(input pc_t halt);
        logic [31:0] cnt [`HWLOOP_NUM];
        pc_t         pc;
        int          taken;
        pc = '0;
        for (int k = 0; k < `HWLOOP_NUM; k++)
            cnt[k] = cfg_count[k];
        exp_q.delete();
        for (int step = 0; step < 1000; step++) begin
            exp_q.push_back(pc);
            if (pc == halt)
                break;
            taken = -1;
            for (int k = `HWLOOP_NUM - 1; k >= 0; k--) begin
                if (pc == cfg_end[k][`PC_AWID-1:0] && cnt[k] >= 32'd2)
                    taken = k;          // lowest index ends up here
            end
            if (taken >= 0) begin
                cnt[taken] = cnt[taken] - 32'd1;
                pc = cfg_start[taken][`PC_AWID-1:0];
            end else begin
                pc = pc + 1'b1;
            end
        end
    endtask

    task automatic run_fetch(input pc_t halt);
        logic [31:0] rd;
        int          n;
        n = 0;
        build_expected(halt);
        wb_write(`REG_HALT, 32'(halt));
        wb_write(`REG_CTRL, 32'h1);
        while (exp_q.size() > 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() > 0) begin
            $display("test %s: issue stream stalled with %0d addresses still expected",
                     cur_test, exp_q.size());
            timeout_hit = 1'b1;
            return;
        end
        repeat (4) @(negedge clk);  // room for any stray transfer
        check_value("issue valid after drain", 32'h0, 32'(issue_valid));
        wb_read(`REG_CTRL, rd);
        check_value("run after halt", 32'h0, rd);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        errs_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors > errs_at_start || timeout_hit) begin
            tests_failed++;
            $display("test %s: failed", cur_test);
        end else begin
            $display("test %s: passed", cur_test);
        end
    endtask

    task automatic run_all();
        logic [31:0] rd;

        begin_test("reset");
        check_value("issue valid", 32'h0, 32'(issue_valid));
        check_value("wb ack", 32'h0, 32'(wb_ack));
        wb_read(`REG_CTRL, rd);
        check_value("ctrl", 32'h0, rd);
        end_test();
        if (timeout_hit)
            return;

        begin_test("readback");
        for (int k = 0; k < `HWLOOP_NUM; k++) begin
            for (int r = 0; r < 3; r++)
                wb_write(loop_adr(k, 2'(r)), reg_pattern(k, r));
        end
        wb_write(`REG_HALT, 32'h0000_2A5A);     // halt holds only PC_AWID bits
        for (int k = 0; k < `HWLOOP_NUM; k++) begin
            for (int r = 0; r < 3; r++) begin
                wb_read(loop_adr(k, 2'(r)), rd);
                check_value($sformatf("loop %0d reg %0d", k, r), reg_pattern(k, r), rd);
            end
        end
        wb_read(`REG_HALT, rd);
        check_value("halt", 32'h0000_2A5A, rd);
        for (int k = 0; k < `HWLOOP_NUM; k++)
            set_loop(k, 32'h0, 32'h0, 32'h0);
        end_test();
        if (timeout_hit)
            return;

        begin_test("straight line");
        run_fetch(pc_t'(9));
        end_test();
        if (timeout_hit)
            return;

        begin_test("single loop");
        set_loop(0, 32'd2, 32'd4, 32'd3);
        run_fetch(pc_t'(6));
        wb_read(loop_adr(0, `REG_COUNT), rd);
        check_value("loop 0 count", 32'd1, rd);
        set_loop(0, 32'd2, 32'd4, 32'd1);   // body once
        run_fetch(pc_t'(6));
        end_test();
        if (timeout_hit)
            return;

        begin_test("nested loops");
        set_loop(0, 32'd3, 32'd4, 32'd2);
        set_loop(1, 32'd2, 32'd5, 32'd3);
        run_fetch(pc_t'(7));
        end_test();
        if (timeout_hit)
            return;

        begin_test("back pressure");
        set_loop(0, 32'd3, 32'd4, 32'd2);
        set_loop(1, 32'd2, 32'd5, 32'd3);
        bp_mode = 1'b1;
        run_fetch(pc_t'(7));
        bp_mode = 1'b0;
        wb_read(loop_adr(0, `REG_COUNT), rd);
        check_value("loop 0 count", 32'd1, rd);
        wb_read(loop_adr(1, `REG_COUNT), rd);
        check_value("loop 1 count", 32'd1, rd);
        end_test();
    endtask

    initial begin
        rst     = 1'b1;
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
        wb_adr  = '0;
        wb_wdat = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        run_all();
        $display("tests run %0d, tests failed %0d, checks %0d, check errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && !timeout_hit) begin
            $display("=== PASS ===");
        end else begin
            if (timeout_hit)
                $display("run stopped early after a timeout");
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
